//--- proc.f
rtl/proc_pkg.sv
rtl/stage_reg.sv
rtl/decode.sv
rtl/hazard.sv
rtl/execute.sv
rtl/proc.sv
sim/proc_tb.sv

//--- Bender.yml
package:
  name: proc

sources:
  # package first, then the stages, then the top level
  - rtl/proc_pkg.sv
  - rtl/stage_reg.sv
  - rtl/decode.sv
  - rtl/hazard.sv
  - rtl/execute.sv
  - rtl/proc.sv
  - target: test
    files:
      - sim/proc_tb.sv

//--- sim/proc_tb.sv
`timescale 1ns/100ps
`default_nettype none
////////////////////////////////////////////////////////////////////////////
// proc testbench
// random instruction stream into the pipeline, an in-order ISA model
// predicts every writeback, error and halt event and its cycle
////////////////////////////////////////////////////////////////////////////
module proc_tb;
    import proc_pkg::*;

    localparam int          N_INSTR       = 400;
    localparam int          RESET_CYCLES  = 10;
    localparam int          EXTRA_STROBES = 4;
    localparam int          LATENCY       = 4;
    localparam int          CYCLE_LIMIT   = RESET_CYCLES + 2 * N_INSTR + 100;
    localparam time         DRIVE_DLY     = 2;
    localparam logic [31:0] SEED          = 32'h6494_ad16;

    typedef enum logic [1:0] {EV_WB, EV_ERR, EV_HALT} event_e;

    // one predicted DUT event
    typedef struct packed {
        event_e      kind;
        reg_idx_t    rd;
        word_t       data;
        logic [31:0] cycle;
    } event_t;

    logic        clk;
    logic        i_reset;
    logic        i_instr_valid;
    instr_t      i_instr;
    logic        o_wb_valid;
    reg_idx_t    o_wb_reg;
    word_t       o_wb_data;
    logic        o_err;
    logic        o_halted;

    int unsigned cyc = 0;
    event_t      expected[$];
    word_t       model_regs[8];
    logic        halted_tb = 1'b0;
    int          n_value_err = 0;
    int          n_timing_err = 0;
    int          n_event_err = 0;

    proc DUT (
        .clk          (clk),
        .i_reset      (i_reset),
        .i_instr_valid(i_instr_valid),
        .i_instr      (i_instr),
        .o_wb_valid   (o_wb_valid),
        .o_wb_reg     (o_wb_reg),
        .o_wb_data    (o_wb_data),
        .o_err        (o_err),
        .o_halted     (o_halted)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // mostly r0..r3 so that dependencies come often
    function automatic reg_idx_t pick_reg();
        if ($urandom % 4 == 0) begin
            return reg_idx_t'($urandom % 8);
        end
        return reg_idx_t'($urandom % 4);
    endfunction

    // legal opcodes 7 times out of 8, HALT only at the end
    function automatic instr_t random_instr();
        instr_t     ins;
        logic [3:0] op;
        if ($urandom % 8 == 0) begin
            op = 4'($urandom % 15);
        end else begin
            op = 4'($urandom % 10);
        end
        ins.i.opcode = opcode_e'(op);
        ins.i.ro     = pick_reg();
        ins.i.rx     = pick_reg();
        ins.i.imm    = 6'($urandom);
        // register forms keep random pad bits
        if (op < 4'd7) begin
            ins.r.ry = pick_reg();
        end
        return ins;
    endfunction

    // ISA rules applied in program order
    task automatic model_step(input instr_t ins);
        event_t     ev;
        logic [3:0] op;
        word_t      a;
        word_t      b;
        word_t      imm;
        word_t      res;
        op       = ins.r.opcode;
        a        = model_regs[ins.r.rx];
        b        = model_regs[ins.r.ry];
        imm      = {{10{ins.i.imm[5]}}, ins.i.imm};
        res      = '0;
        ev.kind  = EV_WB;
        ev.rd    = ins.r.ro;
        ev.cycle = cyc + LATENCY;
        case (op)
            4'd0: res = a + b;
            4'd1: res = a - b;
            4'd2: res = a & b;
            4'd3: res = a | b;
            4'd4: res = a ^ b;
            4'd5: res = a << b[3:0];
            4'd6: res = a >> b[3:0];
            4'd7: res = a + imm;
            4'd8: res = a ^ imm;
            4'd9: res = a << imm[3:0];
            4'd15: ev.kind = EV_HALT;
            default: ev.kind = EV_ERR;
        endcase
        ev.data = res;
        if (ev.kind == EV_WB) begin
            model_regs[ins.r.ro] = res;
        end
        expected.push_back(ev);
    endtask

    task automatic send_instr(input instr_t ins, input logic modeled);
        i_instr_valid = 1'b1;
        i_instr       = ins;
        if (modeled) begin
            model_step(ins);
        end
    endtask

    // inputs change just after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DLY;
        i_instr_valid = 1'b0;
    endtask

    // compare DUT events with the queue head, mid-cycle
    always @(negedge clk) begin : monitor
        event_t ev;
        event_e got_kind;
        logic   got_halt;
        int     got_count;
        if (!i_reset) begin
            if ($isunknown({o_wb_valid, o_err, o_halted})) begin
                $display("** Error @ %0t: unknown value on an output strobe", $time);
                n_value_err++;
            end
            if (halted_tb && !o_halted) begin
                $display("** Error @ %0t: o_halted dropped after halt", $time);
                n_value_err++;
            end
            got_halt  = o_halted && !halted_tb;
            got_count = int'(o_wb_valid) + int'(o_err) + int'(got_halt);
            got_kind  = o_wb_valid ? EV_WB : (o_err ? EV_ERR : EV_HALT);
            if (got_halt) begin
                halted_tb = 1'b1;
            end
            if (got_count > 1) begin
                $display("** Error @ %0t: several output events in one cycle", $time);
                n_event_err++;
            end
            if (got_count != 0) begin
                if (expected.size() == 0) begin
                    $display("** Error @ %0t: output event with nothing expected", $time);
                    n_event_err++;
                end else begin
                    ev = expected.pop_front();
                    if (got_kind != ev.kind) begin
                        $display("** Error @ %0t: event kind %s, expected %s",
                                 $time, got_kind.name(), ev.kind.name());
                        n_value_err++;
                    end else if ((ev.kind == EV_WB) &&
                                 ((o_wb_reg != ev.rd) || (o_wb_data != ev.data))) begin
                        $display("** Error @ %0t: wrote r%0d = %h, expected r%0d = %h",
                                 $time, o_wb_reg, o_wb_data, ev.rd, ev.data);
                        n_value_err++;
                    end
                    if (cyc != ev.cycle) begin
                        $display("** Error @ %0t: event in cycle %0d, expected cycle %0d",
                                 $time, cyc, ev.cycle);
                        n_timing_err++;
                    end
                end
            end else if ((expected.size() != 0) && (expected[0].cycle < cyc)) begin
                ev = expected.pop_front();
                $display("** Error @ %0t: %s event due in cycle %0d never came",
                         $time, ev.kind.name(), ev.cycle);
                n_event_err++;
            end
        end
    end

    // run limit
    initial begin
        wait (cyc >= CYCLE_LIMIT);
        $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("errors: value %0d, timing %0d, event %0d",
                 n_value_err, n_timing_err, n_event_err);
        $display("Something failed");
        $finish;
    end

    initial begin : stimulus
        int          issued;
        int          idles;
        instr_t      ins;
        void'($urandom(SEED));
        issued        = 0;
        idles         = 0;
        i_reset       = 1'b1;
        i_instr_valid = 1'b0;
        i_instr       = '0;
        for (int i = 0; i < 8; i++) begin
            model_regs[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        i_reset = 1'b0;

        // strobe with probability 1/2
        // idle cycles never run far ahead of issued ones
        while (issued < N_INSTR) begin
            if (($urandom % 2 == 0) || (idles >= issued + 8)) begin
                ins = random_instr();
                send_instr(ins, 1'b1);
                issued++;
            end else begin
                idles++;
            end
            next_cycle();
        end

        ins          = random_instr();
        ins.i.opcode = opcode_e'(4'd15);
        send_instr(ins, 1'b1);
        next_cycle();
        // back to back behind HALT, all must be dropped
        repeat (EXTRA_STROBES) begin
            send_instr(random_instr(), 1'b0);
            next_cycle();
        end

        while (expected.size() != 0) begin
            next_cycle();
        end
        // room for stray events from the dropped strobes
        repeat (2 * LATENCY) next_cycle();
        if (!halted_tb) begin
            $display("HALT never raised o_halted");
            n_event_err++;
        end

        $display("errors: value %0d, timing %0d, event %0d",
                 n_value_err, n_timing_err, n_event_err);
        if ((n_value_err + n_timing_err + n_event_err) == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
`default_nettype wire

//--- rtl/proc.sv
`timescale 1ns/100ps
`default_nettype none
////////////////////////////////////////////////////////////////////////////
// proc
// 5-stage in-order 16-bit integer pipeline, IF ID EX MEM WB
// instructions are pushed in one per strobe, results leave as
// writeback strobes, 4 cycles after intake
////////////////////////////////////////////////////////////////////////////
module proc (
    input  wire                     clk,
    input  wire                     i_reset,
    input  wire                     i_instr_valid,
    input  wire proc_pkg::instr_t   i_instr,
    output logic                    o_wb_valid,
    output proc_pkg::reg_idx_t      o_wb_reg,
    output proc_pkg::word_t         o_wb_data,
    output logic                    o_err,
    output logic                    o_halted
);
    import proc_pkg::*;

    // intake
    logic     in_valid;
    if_id_t   in_data;
    logic     halt_seen;
    logic     halted_q;
    // IF/ID and decode
    logic     ifid_valid;
    if_id_t   ifid;
    logic     id_valid;
    id_ex_t   id_out;
    logic     id_halt_seen;
    // ID/EX and execute
    logic     idex_valid;
    id_ex_t   idex;
    fwd_sel_e fwd_a;
    fwd_sel_e fwd_b;
    ex_mem_t  ex_out;
    // EX/MEM and MEM/WB
    logic     exmem_valid;
    ex_mem_t  exmem;
    logic     memwb_valid;
    ex_mem_t  memwb;

    // once HALT is in decode nothing more comes in
    assign in_valid      = i_instr_valid && !halt_seen && !id_halt_seen;
    assign in_data.instr = i_instr;

    // BOUNDARY IF/ID
    stage_reg #(.T(if_id_t)) fl_if2id (
        .clk    (clk),
        .i_reset(i_reset),
        .i_valid(in_valid),
        .i_data (in_data),
        .o_valid(ifid_valid),
        .o_data (ifid)
    );

    decode decode (
        .clk        (clk),
        .i_reset    (i_reset),
        .i_valid    (ifid_valid),
        .i_instr    (ifid.instr),
        .i_wb_en    (o_wb_valid),
        .i_wb_reg   (memwb.ro),
        .i_wb_data  (memwb.result),
        .o_valid    (id_valid),
        .o_id_ex    (id_out),
        .o_halt_seen(id_halt_seen)
    );

    // BOUNDARY ID/EX
    stage_reg #(.T(id_ex_t)) fl_id2ex (
        .clk    (clk),
        .i_reset(i_reset),
        .i_valid(id_valid),
        .i_data (id_out),
        .o_valid(idex_valid),
        .o_data (idex)
    );

    hazard hazard (
        .i_ex_rx      (idex.rx),
        .i_ex_ry      (idex.ry),
        .i_exmem_valid(exmem_valid),
        .i_exmem      (exmem),
        .i_memwb_valid(memwb_valid),
        .i_memwb      (memwb),
        .o_fwd_a      (fwd_a),
        .o_fwd_b      (fwd_b)
    );

    execute execute (
        .i_id_ex       (idex),
        .i_fwd_a       (fwd_a),
        .i_fwd_b       (fwd_b),
        .i_exmem_result(exmem.result),
        .i_memwb_result(memwb.result),
        .o_ex_mem      (ex_out)
    );

    // BOUNDARY EX/MEM
    stage_reg #(.T(ex_mem_t)) fl_ex2mem (
        .clk    (clk),
        .i_reset(i_reset),
        .i_valid(idex_valid),
        .i_data (ex_out),
        .o_valid(exmem_valid),
        .o_data (exmem)
    );

    // no data memory, the MEM slot hands EX/MEM straight on
    stage_reg #(.T(ex_mem_t)) fl_mem2wb (
        .clk    (clk),
        .i_reset(i_reset),
        .i_valid(exmem_valid),
        .i_data (exmem),
        .o_valid(memwb_valid),
        .o_data (memwb)
    );

    // halt bookkeeping, both sticky until reset
    always_ff @(posedge clk) begin
        if (i_reset) begin
            halt_seen <= 1'b0;
            halted_q  <= 1'b0;
        end else begin
            if (id_halt_seen) begin
                halt_seen <= 1'b1;
            end
            if (memwb_valid && memwb.halt) begin
                halted_q <= 1'b1;
            end
        end
    end

    // writeback selection
    assign o_wb_valid = memwb_valid && memwb.writes_reg;
    assign o_wb_reg   = memwb.ro;
    assign o_wb_data  = memwb.result;
    assign o_err      = memwb_valid && memwb.illegal;
    // high already in the cycle HALT sits in MEM/WB
    assign o_halted   = halted_q || (memwb_valid && memwb.halt);

    // intake gating has to drain the pipe behind HALT
    a_quiet_after_halt: assert property (
        @(posedge clk) disable iff (i_reset) o_halted |-> !(o_wb_valid || o_err)
    ) else $error("proc: activity after halt");

endmodule
`default_nettype wire

//--- rtl/execute.sv
`timescale 1ns/100ps
`default_nettype none
////////////////////////////////////////////////////////////////////////////
// execute
// operand forwarding muxes, immediate select and the 16-bit ALU
////////////////////////////////////////////////////////////////////////////
module execute (
    input  wire proc_pkg::id_ex_t   i_id_ex,
    input  wire proc_pkg::fwd_sel_e i_fwd_a,
    input  wire proc_pkg::fwd_sel_e i_fwd_b,
    input  wire proc_pkg::word_t    i_exmem_result,
    input  wire proc_pkg::word_t    i_memwb_result,
    output proc_pkg::ex_mem_t       o_ex_mem
);
    import proc_pkg::*;

    word_t              op_a;
    word_t              op_b_reg;
    word_t              op_b;
    word_t              result;
    logic [SHAMT_W-1:0] shamt;

    // own register value unless a newer one is still in flight
    function automatic word_t fwd_mux(
        fwd_sel_e sel,
        word_t    own,
        word_t    from_exmem,
        word_t    from_memwb
    );
        word_t v;
        case (sel)
            FWD_EXMEM: v = from_exmem;
            FWD_MEMWB: v = from_memwb;
            default:   v = own;
        endcase
        return v;
    endfunction

    assign op_a     = fwd_mux(i_fwd_a, i_id_ex.vx, i_exmem_result, i_memwb_result);
    assign op_b_reg = fwd_mux(i_fwd_b, i_id_ex.vy, i_exmem_result, i_memwb_result);
    assign op_b     = i_id_ex.use_imm ? i_id_ex.imm : op_b_reg;

    // shift amount, upper bits ignored
    assign shamt = op_b[SHAMT_W-1:0];

    always_comb begin
        case (i_id_ex.alu_op)
            ALU_ADD: result = op_a + op_b;
            ALU_SUB: result = op_a - op_b;
            ALU_AND: result = op_a & op_b;
            ALU_OR:  result = op_a | op_b;
            ALU_XOR: result = op_a ^ op_b;
            ALU_SLL: result = op_a << shamt;
            ALU_SRL: result = op_a >> shamt;
            default: result = '0;
        endcase
    end

    // control bits ride along untouched
    always_comb begin
        o_ex_mem.halt       = i_id_ex.halt;
        o_ex_mem.illegal    = i_id_ex.illegal;
        o_ex_mem.writes_reg = i_id_ex.writes_reg;
        o_ex_mem.ro         = i_id_ex.ro;
        o_ex_mem.result     = result;
    end

endmodule
`default_nettype wire

//--- rtl/hazard.sv
`timescale 1ns/100ps
`default_nettype none
////////////////////////////////////////////////////////////////////////////
// hazard
// forwarding unit, picks the source of each execute operand
// the younger producer in EX/MEM beats the one in MEM/WB
////////////////////////////////////////////////////////////////////////////
module hazard (
    input  wire proc_pkg::reg_idx_t i_ex_rx,
    input  wire proc_pkg::reg_idx_t i_ex_ry,
    input  wire                     i_exmem_valid,
    input  wire proc_pkg::ex_mem_t  i_exmem,
    input  wire                     i_memwb_valid,
    input  wire proc_pkg::ex_mem_t  i_memwb,
    output proc_pkg::fwd_sel_e      o_fwd_a,
    output proc_pkg::fwd_sel_e      o_fwd_b
);
    import proc_pkg::*;

    // stage holds a result headed for the register file
    logic exmem_live;
    logic memwb_live;

    function automatic fwd_sel_e pick_source(reg_idx_t r);
        fwd_sel_e sel;
        sel = FWD_NONE;
        if (exmem_live && (i_exmem.ro == r)) begin
            sel = FWD_EXMEM;
        end else if (memwb_live && (i_memwb.ro == r)) begin
            sel = FWD_MEMWB;
        end
        return sel;
    endfunction

    assign exmem_live = i_exmem_valid && i_exmem.writes_reg;
    assign memwb_live = i_memwb_valid && i_memwb.writes_reg;

    always_comb begin
        o_fwd_a = pick_source(i_ex_rx);
        o_fwd_b = pick_source(i_ex_ry);
    end

    // an empty stage must never feed an operand
    always_comb begin
        if (!i_exmem_valid) begin
            assert ((o_fwd_a != FWD_EXMEM) && (o_fwd_b != FWD_EXMEM))
                else $error("hazard: forwarding from empty EX/MEM");
        end
        if (!i_memwb_valid) begin
            assert ((o_fwd_a != FWD_MEMWB) && (o_fwd_b != FWD_MEMWB))
                else $error("hazard: forwarding from empty MEM/WB");
        end
    end

endmodule
`default_nettype wire

//--- rtl/decode.sv
`timescale 1ns/100ps
`default_nettype none
////////////////////////////////////////////////////////////////////////////
// decode
// splits instruction fields, classifies the opcode and reads operands
// from the 8 x 16 register file, which bypasses a same-cycle write
////////////////////////////////////////////////////////////////////////////
module decode (
    input  wire                     clk,
    input  wire                     i_reset,
    input  wire                     i_valid,
    input  wire proc_pkg::instr_t   i_instr,
    input  wire                     i_wb_en,
    input  wire proc_pkg::reg_idx_t i_wb_reg,
    input  wire proc_pkg::word_t    i_wb_data,
    output logic                    o_valid,
    output proc_pkg::id_ex_t        o_id_ex,
    output logic                    o_halt_seen
);
    import proc_pkg::*;

    // architectural registers
    word_t    regs [NUM_REGS];

    opcode_e  opcode;
    reg_idx_t rx;
    reg_idx_t ry;
    alu_op_e  alu_op;
    logic     use_imm;
    logic     writes_reg;
    logic     halt;
    logic     illegal;

    // a write landing this cycle wins over the stored value
    function automatic word_t read_reg(reg_idx_t r);
        word_t v;
        v = regs[r];
        if (i_wb_en && (i_wb_reg == r)) begin
            v = i_wb_data;
        end
        return v;
    endfunction

    assign opcode = i_instr.r.opcode;
    assign rx     = i_instr.r.rx;
    assign ry     = i_instr.r.ry;

    // opcode classification
    always_comb begin
        alu_op     = ALU_ADD;
        use_imm    = 1'b0;
        writes_reg = 1'b1;
        halt       = 1'b0;
        illegal    = 1'b0;
        case (opcode)
            OP_ADD:  alu_op = ALU_ADD;
            OP_SUB:  alu_op = ALU_SUB;
            OP_AND:  alu_op = ALU_AND;
            OP_OR:   alu_op = ALU_OR;
            OP_XOR:  alu_op = ALU_XOR;
            OP_SLL:  alu_op = ALU_SLL;
            OP_SRL:  alu_op = ALU_SRL;
            OP_ADDI: begin
                alu_op  = ALU_ADD;
                use_imm = 1'b1;
            end
            OP_XORI: begin
                alu_op  = ALU_XOR;
                use_imm = 1'b1;
            end
            OP_SLLI: begin
                alu_op  = ALU_SLL;
                use_imm = 1'b1;
            end
            OP_HALT: begin
                writes_reg = 1'b0;
                halt       = 1'b1;
            end
            // 10..14, nothing written
            default: begin
                writes_reg = 1'b0;
                illegal    = 1'b1;
            end
        endcase
    end

    // cleared on reset so the first reads see zero
    always_ff @(posedge clk) begin
        if (i_reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wb_en) begin
            regs[i_wb_reg] <= i_wb_data;
        end
    end

    always_comb begin
        o_id_ex.halt       = halt;
        o_id_ex.illegal    = illegal;
        o_id_ex.writes_reg = writes_reg;
        o_id_ex.alu_op     = alu_op;
        o_id_ex.use_imm    = use_imm;
        o_id_ex.rx         = rx;
        o_id_ex.ry         = ry;
        o_id_ex.ro         = i_instr.r.ro;
        o_id_ex.vx         = read_reg(rx);
        o_id_ex.vy         = read_reg(ry);
        // sign-extend imm6
        o_id_ex.imm = {{(WORD_W-IMM_W){i_instr.i.imm[IMM_W-1]}}, i_instr.i.imm};
    end

    // combinational stage, valid passes straight on
    assign o_valid     = i_valid;
    assign o_halt_seen = o_valid && halt;

    // writeback, error and halt strobes are meant to be exclusive
    a_class_exclusive: assert property (
        @(posedge clk) disable iff (i_reset)
        o_valid |-> !(o_id_ex.writes_reg && (o_id_ex.illegal || o_id_ex.halt))
    ) else $error("decode: writes_reg set with illegal or halt");

endmodule
`default_nettype wire

//--- rtl/stage_reg.sv
`timescale 1ns/100ps
`default_nettype none
////////////////////////////////////////////////////////////////////////////
// stage_reg
// pipeline boundary register, one cycle of latency
// payload type is a parameter so one block serves every boundary
////////////////////////////////////////////////////////////////////////////
module stage_reg #(
    parameter type T = logic
) (
    input  wire   clk,
    input  wire   i_reset,
    input  wire   i_valid,
    input  wire T i_data,
    output logic  o_valid,
    output T      o_data
);

    // valid is the only control state here
    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

    // payload follows every cycle
    // meaningless while o_valid is low
    always_ff @(posedge clk) begin
        o_data <= i_data;
    end

    // a stray X on valid would poison every later stage
    a_valid_known: assert property (
        @(posedge clk) disable iff (i_reset) !$isunknown(o_valid)
    ) else $error("stage_reg: o_valid unknown");

endmodule
`default_nettype wire

//--- rtl/proc_pkg.sv
`default_nettype none
////////////////////////////////////////////////////////////////////////////
// proc shared definitions
// widths, opcode and ALU encodings, the 16-bit instruction layout and
// the payloads carried across the pipeline boundaries
////////////////////////////////////////////////////////////////////////////
package proc_pkg;

    // fixed by the ISA
    localparam int WORD_W    = 16;
    localparam int REG_IDX_W = 3;
    localparam int NUM_REGS  = 8;
    localparam int OPCODE_W  = 4;
    localparam int IMM_W     = 6;
    // shifts look at the low 4 bits of the amount only
    localparam int SHAMT_W   = 4;

    typedef logic [WORD_W-1:0]    word_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // 10..14 left unassigned, decoded as illegal
    typedef enum logic [OPCODE_W-1:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_AND  = 4'd2,
        OP_OR   = 4'd3,
        OP_XOR  = 4'd4,
        OP_SLL  = 4'd5,
        OP_SRL  = 4'd6,
        OP_ADDI = 4'd7,
        OP_XORI = 4'd8,
        OP_SLLI = 4'd9,
        OP_HALT = 4'd15
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL
    } alu_op_e;

    // operand source picked by the forwarding unit
    typedef enum logic [1:0] {
        FWD_NONE,
        FWD_EXMEM,
        FWD_MEMWB
    } fwd_sel_e;

    // register form, low 3 bits unused
    typedef struct packed {
        opcode_e    opcode;
        reg_idx_t   ro;
        reg_idx_t   rx;
        reg_idx_t   ry;
        logic [2:0] pad;
    } instr_r_t;

    // immediate form, imm overlaps ry
    typedef struct packed {
        opcode_e          opcode;
        reg_idx_t         ro;
        reg_idx_t         rx;
        logic [IMM_W-1:0] imm;
    } instr_i_t;

    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_t;

    typedef struct packed {
        instr_t instr;
    } if_id_t;

    typedef struct packed {
        logic     halt;
        logic     illegal;
        logic     writes_reg;
        alu_op_e  alu_op;
        logic     use_imm;
        reg_idx_t rx;
        reg_idx_t ry;
        reg_idx_t ro;
        word_t    vx;
        word_t    vy;
        // already sign-extended
        word_t    imm;
    } id_ex_t;

    // same shape at EX/MEM and MEM/WB
    typedef struct packed {
        logic     halt;
        logic     illegal;
        logic     writes_reg;
        reg_idx_t ro;
        word_t    result;
    } ex_mem_t;

endpackage
`default_nettype wire
